// File: all.f
+incdir+hdl
hdl/buffer_pkg.sv
hdl/bank_write_if.sv
hdl/capture_control.sv
hdl/sample_banks.sv
hdl/readout_dma.sv
hdl/sample_buffer.sv
verif/sample_buffer_chk.sv
verif/sample_buffer_tb.sv

// File: hdl/bank_write_if.sv
// ==========================================================
// write side link between capture control and the banks
// ==========================================================
`timescale 1ns/100ps

interface bank_write_if import buffer_pkg::*; ();

  logic          write_enable;
  logic          clear_counts;
  banking_mode_t banking_mode;
  depth_word_t   depths;
  logic          full;

  modport ctrl (
    output write_enable,
    output clear_counts,
    output banking_mode,
    input  depths,
    input  full
  );

  modport bank (
    input  write_enable,
    input  clear_counts,
    input  banking_mode,
    output depths,
    output full
  );

endinterface

// File: hdl/buffer_pkg.sv
// ==========================================================
// shared types for the sample buffer
// capture states, banking mode, sample and depth words
// ==========================================================
`include "buffer_settings.svh"

package buffer_pkg;

  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_ARMED,
    CAP_CAPTURING,
    CAP_HOLD
  } capture_state_t;

  // 0 -> one channel, 1 -> two channels, 2 -> four channels
  typedef logic [1:0] banking_mode_t;

  typedef logic [`BUF_SAMPLE_WIDTH-1:0] sample_t;

  typedef logic [$clog2(`BUF_CHANNELS)-1:0] channel_t;

  // holds 0 up to the full pooled storage of one channel
  localparam int DEPTH_WIDTH = $clog2(`BUF_CHANNELS * `BUF_BANK_DEPTH) + 1;

  typedef logic [DEPTH_WIDTH-1:0] depth_t;

  // channel 0 in the low bits
  typedef depth_t [`BUF_CHANNELS-1:0] depth_word_t;

endpackage

// File: hdl/buffer_settings.svh
// ==========================================================
// sample buffer sizing macros
// channel count, sample width, bank depth, read latency
// ==========================================================
`ifndef BUFFER_SETTINGS_SVH
`define BUFFER_SETTINGS_SVH

// number of sample channels, also the number of banks
`define BUF_CHANNELS 4

// bits per stored sample
`define BUF_SAMPLE_WIDTH 16

// words per bank, total storage is channels times this
`define BUF_BANK_DEPTH 16

// cycles from read enable to read data
`define BUF_READ_LATENCY 2

`endif

// File: hdl/capture_control.sv
// ==========================================================
// capture FSM with arm, start, stop, full and reset handling
// one-shot write depth report on entry to hold
// ==========================================================
`timescale 1ns/100ps
`include "buffer_settings.svh"

module capture_control import buffer_pkg::*; (
  input  logic           ps_clk,
  input  logic           ps_reset,
  input  logic           arm_i,
  input  logic           sw_start_i,
  input  logic           sw_stop_i,
  input  logic           hw_start_i,
  input  logic           hw_stop_i,
  input  logic           capture_reset_i,
  input  banking_mode_t  banking_mode_i,
  bank_write_if.ctrl     bank_if,
  output logic           capture_full_o,
  output depth_word_t    write_depth_o,
  output logic           write_depth_valid_o,
  input  logic           write_depth_ready_i,
  output capture_state_t state_o,
  output banking_mode_t  mode_o
);

  localparam banking_mode_t MAX_MODE = banking_mode_t'($clog2(`BUF_CHANNELS));

  capture_state_t state_q, state_d;
  banking_mode_t  mode_q;
  depth_word_t    depth_q;
  logic           full_q;
  logic           depth_valid_q;
  logic           arm_ok;
  logic           start_ok;
  logic           stop_req;
  logic           enter_hold;

  always_comb begin
    arm_ok   = arm_i && (state_q == CAP_IDLE || state_q == CAP_HOLD);
    // hardware start only counts once armed
    start_ok = (sw_start_i && state_q != CAP_CAPTURING) ||
               (hw_start_i && state_q == CAP_ARMED);
    stop_req = sw_stop_i || hw_stop_i;

    state_d = state_q;
    if (capture_reset_i) begin
      state_d = CAP_IDLE;
    end else if (start_ok) begin
      state_d = CAP_CAPTURING;
    end else if (arm_ok) begin
      state_d = CAP_ARMED;
    end else if (state_q == CAP_CAPTURING && (stop_req || bank_if.full)) begin
      state_d = CAP_HOLD;
    end
    enter_hold = (state_d == CAP_HOLD) && (state_q != CAP_HOLD);
  end

  // samples seen together with a stop or reset strobe are dropped
  assign bank_if.write_enable = (state_q == CAP_CAPTURING) && !stop_req && !capture_reset_i;
  assign bank_if.clear_counts = capture_reset_i || start_ok || arm_ok;
  assign bank_if.banking_mode = mode_q;

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      state_q       <= CAP_IDLE;
      mode_q        <= '0;
      full_q        <= 1'b0;
      depth_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start_ok) begin
        mode_q <= (banking_mode_i > MAX_MODE) ? MAX_MODE : banking_mode_i;
      end
      if (bank_if.clear_counts) begin
        full_q <= 1'b0;
      end else if (bank_if.full) begin
        full_q <= 1'b1;
      end
      if (capture_reset_i) begin
        depth_valid_q <= 1'b0;
      end else if (enter_hold) begin
        depth_valid_q <= 1'b1;
      end else if (write_depth_ready_i) begin
        depth_valid_q <= 1'b0;
      end
    end
  end

  // banks present next-cycle counts, so this catches the final sample
  always_ff @(posedge ps_clk) begin
    if (enter_hold) begin
      depth_q <= bank_if.depths;
    end
  end

  assign capture_full_o      = full_q;
  assign write_depth_o       = depth_q;
  assign write_depth_valid_o = depth_valid_q;
  assign state_o             = state_q;
  assign mode_o              = mode_q;

endmodule

// File: hdl/readout_dma.sv
// ==========================================================
// readout engine streaming stored samples channel by channel
// credit-limited reads into a small output FIFO
// ==========================================================
`timescale 1ns/100ps
`include "buffer_settings.svh"

module readout_dma import buffer_pkg::*; (
  input  logic           ps_clk,
  input  logic           ps_reset,
  input  logic           readout_start_i,
  input  logic           readout_reset_i,
  input  logic           capture_reset_i,
  input  capture_state_t state_i,
  input  banking_mode_t  mode_i,
  input  depth_word_t    depths_i,
  output logic           rd_en_o,
  output channel_t       rd_channel_o,
  output depth_t         rd_addr_o,
  input  sample_t        rd_data_i,
  output sample_t        readout_data_o,
  output logic           readout_valid_o,
  input  logic           readout_ready_i,
  output logic           readout_last_o
);

  localparam int LAT        = `BUF_READ_LATENCY;
  localparam int FIFO_DEPTH = LAT + 2;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);
  localparam int CH_W       = $bits(channel_t);

  logic                  running_q;
  channel_t              chan_q;
  depth_t                addr_q;
  logic [LAT-1:0]        vld_pipe;
  logic [LAT-1:0]        last_pipe;
  sample_t               fifo_data [FIFO_DEPTH];
  logic [FIFO_DEPTH-1:0] fifo_last;
  logic [PTR_W-1:0]      wr_ptr, rd_ptr;
  logic [CNT_W-1:0]      fifo_cnt;
  logic [CH_W:0]         first_ch, next_ch;
  logic                  abort, start_ok, issue, push, pop;
  logic                  space_ok, last_addr, is_last;

  // finds the lowest non-empty active channel at or above from
  // top bit set when one was found
  function automatic logic [CH_W:0] find_channel(input int from, input depth_word_t d,
                                                 input banking_mode_t m);
    logic [CH_W:0] res;
    res = '0;
    for (int c = `BUF_CHANNELS - 1; c >= 0; c--) begin
      if (c >= from && c < (1 << m) && d[c] != '0) begin
        res = {1'b1, CH_W'(c)};
      end
    end
    return res;
  endfunction

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_comb begin
    abort     = readout_reset_i || capture_reset_i || (state_i != CAP_HOLD);
    first_ch  = find_channel(0, depths_i, mode_i);
    next_ch   = find_channel(int'(chan_q) + 1, depths_i, mode_i);
    start_ok  = readout_start_i && !running_q && first_ch[CH_W];
    last_addr = (addr_q == depths_i[chan_q] - 1'b1);
    is_last   = last_addr && !next_ch[CH_W];
    // buffered plus in-flight words must fit the FIFO
    space_ok  = (int'(fifo_cnt) + $countones(vld_pipe)) < FIFO_DEPTH;
    issue     = running_q && space_ok && readout_ready_i;
    push      = vld_pipe[LAT-1];
    pop       = readout_valid_o && readout_ready_i;
  end

  always_ff @(posedge ps_clk) begin
    if (ps_reset || abort) begin
      running_q <= 1'b0;
      chan_q    <= '0;
      addr_q    <= '0;
      vld_pipe  <= '0;
      last_pipe <= '0;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fifo_cnt  <= '0;
      fifo_last <= '0;
    end else begin
      vld_pipe  <= (vld_pipe << 1) | LAT'(issue);
      last_pipe <= (last_pipe << 1) | LAT'(issue && is_last);
      if (start_ok) begin
        running_q <= 1'b1;
        chan_q    <= first_ch[CH_W-1:0];
        addr_q    <= '0;
      end else if (issue) begin
        if (!last_addr) begin
          addr_q <= addr_q + 1'b1;
        end else if (next_ch[CH_W]) begin
          chan_q <= next_ch[CH_W-1:0];
          addr_q <= '0;
        end else begin
          running_q <= 1'b0;
        end
      end
      if (push) begin
        wr_ptr            <= ptr_inc(wr_ptr);
        fifo_last[wr_ptr] <= last_pipe[LAT-1];
      end
      if (pop) begin
        rd_ptr            <= ptr_inc(rd_ptr);
        // a word that leaves gives up its last mark
        fifo_last[rd_ptr] <= 1'b0;
      end
      fifo_cnt <= fifo_cnt + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge ps_clk) begin
    if (push) begin
      fifo_data[wr_ptr] <= rd_data_i;
    end
  end

  assign rd_en_o         = issue;
  assign rd_channel_o    = chan_q;
  assign rd_addr_o       = addr_q;
  assign readout_valid_o = (fifo_cnt != '0);
  assign readout_data_o  = fifo_data[rd_ptr];
  assign readout_last_o  = fifo_last[rd_ptr];

endmodule

// File: hdl/sample_banks.sv
// ==========================================================
// pooled bank memories with per-channel write counters
// full detection and a pipelined read port
// ==========================================================
`timescale 1ns/100ps
`include "buffer_settings.svh"

module sample_banks import buffer_pkg::*; (
  input  logic                        ps_clk,
  input  logic                        ps_reset,
  input  sample_t [`BUF_CHANNELS-1:0] sample_data_i,
  input  logic [`BUF_CHANNELS-1:0]    sample_valid_i,
  bank_write_if.bank                  bank_if,
  input  logic                        rd_en_i,
  input  channel_t                    rd_channel_i,
  input  depth_t                      rd_addr_i,
  output sample_t                     rd_data_o
);

  localparam int BANKS  = `BUF_CHANNELS;
  localparam int TOTAL  = BANKS * `BUF_BANK_DEPTH;
  localparam int ADDR_W = $clog2(TOTAL);
  localparam int OFF_W  = $clog2(`BUF_BANK_DEPTH);
  localparam int LAT    = `BUF_READ_LATENCY;

  typedef logic [ADDR_W-1:0] flat_addr_t;

  sample_t          mem [BANKS][`BUF_BANK_DEPTH];
  sample_t          rd_pipe [LAT];
  depth_word_t      count_q, count_d;
  logic             full_q;
  logic             fill_now;
  depth_t           capacity;
  logic [BANKS-1:0] ch_write;
  flat_addr_t       wr_flat [BANKS];
  flat_addr_t       rd_flat;
  logic [BANKS-1:0] bank_we;
  logic [OFF_W-1:0] bank_off [BANKS];
  sample_t          bank_wdata [BANKS];

  // storage per active channel shrinks as more channels share the banks
  assign capacity = depth_t'(TOTAL >> bank_if.banking_mode);

  // a channel's samples are contiguous: flat = channel * capacity + count
  // the top flat bits pick the bank, the low bits the offset inside it
  always_comb begin
    fill_now = 1'b0;
    bank_we  = '0;
    for (int b = 0; b < BANKS; b++) begin
      bank_off[b]   = '0;
      bank_wdata[b] = '0;
    end
    for (int c = 0; c < BANKS; c++) begin
      wr_flat[c]  = flat_addr_t'(c * capacity) + flat_addr_t'(count_q[c]);
      ch_write[c] = bank_if.write_enable && !full_q && sample_valid_i[c] &&
                    (c < (1 << bank_if.banking_mode));
      count_d[c]  = bank_if.clear_counts ? '0 : count_q[c] + depth_t'(ch_write[c]);
      if (ch_write[c]) begin
        bank_we[wr_flat[c][ADDR_W-1:OFF_W]]    = 1'b1;
        bank_off[wr_flat[c][ADDR_W-1:OFF_W]]   = wr_flat[c][OFF_W-1:0];
        bank_wdata[wr_flat[c][ADDR_W-1:OFF_W]] = sample_data_i[c];
        if (count_q[c] == capacity - 1'b1) begin
          fill_now = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      count_q <= '0;
      full_q  <= 1'b0;
    end else begin
      count_q <= count_d;
      if (bank_if.clear_counts) begin
        full_q <= 1'b0;
      end else if (fill_now) begin
        full_q <= 1'b1;
      end
    end
  end

  assign rd_flat = flat_addr_t'(rd_channel_i * capacity) + flat_addr_t'(rd_addr_i);

  always_ff @(posedge ps_clk) begin
    for (int b = 0; b < BANKS; b++) begin
      if (bank_we[b]) begin
        mem[b][bank_off[b]] <= bank_wdata[b];
      end
    end
    if (rd_en_i) begin
      rd_pipe[0] <= mem[rd_flat[ADDR_W-1:OFF_W]][rd_flat[OFF_W-1:0]];
    end
    for (int s = 1; s < LAT; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];
    end
  end

  assign rd_data_o      = rd_pipe[LAT-1];
  // counts including this cycle's writes
  assign bank_if.depths = count_d;
  assign bank_if.full   = full_q || fill_now;

endmodule

// File: hdl/sample_buffer.sv
// ==========================================================
// multichannel sample capture buffer top level
// ==========================================================
`timescale 1ns/100ps
`include "buffer_settings.svh"

module sample_buffer import buffer_pkg::*; (
  input  logic                        ps_clk,
  input  logic                        ps_reset,
  input  logic                        arm_i,
  input  logic                        sw_start_i,
  input  logic                        sw_stop_i,
  input  logic                        hw_start_i,
  input  logic                        hw_stop_i,
  input  logic                        capture_reset_i,
  input  logic                        readout_start_i,
  input  logic                        readout_reset_i,
  input  banking_mode_t               banking_mode_i,
  input  sample_t [`BUF_CHANNELS-1:0] sample_data_i,
  input  logic [`BUF_CHANNELS-1:0]    sample_valid_i,
  output logic                        capture_full_o,
  output depth_word_t                 write_depth_o,
  output logic                        write_depth_valid_o,
  input  logic                        write_depth_ready_i,
  output sample_t                     readout_data_o,
  output logic                        readout_valid_o,
  input  logic                        readout_ready_i,
  output logic                        readout_last_o
);

  bank_write_if   bank_if ();
  capture_state_t state;
  banking_mode_t  mode;
  logic           rd_en;
  channel_t       rd_channel;
  depth_t         rd_addr;
  sample_t        rd_data;

  capture_control u_capture_control (
    .ps_clk,
    .ps_reset,
    .arm_i,
    .sw_start_i,
    .sw_stop_i,
    .hw_start_i,
    .hw_stop_i,
    .capture_reset_i,
    .banking_mode_i,
    .bank_if             (bank_if.ctrl),
    .capture_full_o,
    .write_depth_o,
    .write_depth_valid_o,
    .write_depth_ready_i,
    .state_o             (state),
    .mode_o              (mode)
  );

  sample_banks u_sample_banks (
    .ps_clk,
    .ps_reset,
    .sample_data_i,
    .sample_valid_i,
    .bank_if      (bank_if.bank),
    .rd_en_i      (rd_en),
    .rd_channel_i (rd_channel),
    .rd_addr_i    (rd_addr),
    .rd_data_o    (rd_data)
  );

  // readout sees the live counts, which hold still during hold
  readout_dma u_readout_dma (
    .ps_clk,
    .ps_reset,
    .readout_start_i,
    .readout_reset_i,
    .capture_reset_i,
    .state_i         (state),
    .mode_i          (mode),
    .depths_i        (bank_if.depths),
    .rd_en_o         (rd_en),
    .rd_channel_o    (rd_channel),
    .rd_addr_o       (rd_addr),
    .rd_data_i       (rd_data),
    .readout_data_o,
    .readout_valid_o,
    .readout_ready_i,
    .readout_last_o
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the sample buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module sample_buffer_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vsample_buffer_tb +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1

// File: verif/sample_buffer_chk.sv
// ==========================================================
// bound assertions on the sample buffer outputs
// handshake stability and values after reset
// ==========================================================
`timescale 1ns/100ps

module sample_buffer_chk import buffer_pkg::*; (
  input logic        ps_clk,
  input logic        ps_reset,
  input logic        capture_reset_i,
  input logic        readout_reset_i,
  input logic        capture_full_i,
  input depth_word_t write_depth_i,
  input logic        write_depth_valid_i,
  input logic        write_depth_ready_i,
  input sample_t     readout_data_i,
  input logic        readout_valid_i,
  input logic        readout_ready_i,
  input logic        readout_last_i
);

  int unsigned failures = 0;

  // a stalled stream word holds until taken
  stream_stable: assert property (@(posedge ps_clk) disable iff (ps_reset)
    readout_valid_i && !readout_ready_i && !readout_reset_i && !capture_reset_i
    |=> readout_valid_i && $stable(readout_data_i) && $stable(readout_last_i))
    else begin
      $error("readout word changed while stalled");
      failures++;
    end

  depth_stable: assert property (@(posedge ps_clk) disable iff (ps_reset)
    write_depth_valid_i && !write_depth_ready_i && !capture_reset_i
    |=> write_depth_valid_i && $stable(write_depth_i))
    else begin
      $error("write depth word changed while stalled");
      failures++;
    end

  last_needs_valid: assert property (@(posedge ps_clk) disable iff (ps_reset)
    readout_last_i |-> readout_valid_i)
    else begin
      $error("readout last raised without valid");
      failures++;
    end

  reset_values: assert property (@(posedge ps_clk)
    ps_reset |=> !write_depth_valid_i && !readout_valid_i && !readout_last_i && !capture_full_i)
    else begin
      $error("output controls not low after reset");
      failures++;
    end

endmodule

// File: verif/sample_buffer_tb.sv
// ==========================================================
// testbench for the sample capture buffer
// file driven capture tests, depth word and readout checks
// ==========================================================
`timescale 1ns/100ps
`include "buffer_settings.svh"

module sample_buffer_tb import buffer_pkg::*; ();

  localparam int MAX_TESTS = 32;
  localparam int TOTAL     = `BUF_CHANNELS * `BUF_BANK_DEPTH;

  logic                        ps_clk;
  logic                        ps_reset;
  logic                        arm;
  logic                        sw_start;
  logic                        sw_stop;
  logic                        hw_start;
  logic                        hw_stop;
  logic                        capture_reset;
  logic                        readout_start;
  logic                        readout_reset;
  banking_mode_t               banking_mode;
  sample_t [`BUF_CHANNELS-1:0] sample_data;
  logic [`BUF_CHANNELS-1:0]    sample_valid;
  logic                        capture_full;
  depth_word_t                 write_depth;
  logic                        depth_valid;
  logic                        depth_ready;
  sample_t                     readout_data;
  logic                        readout_valid;
  logic                        readout_ready;
  logic                        readout_last;

  // test columns are mode, trigger, stop, cycles, four depths and readout reset
  int      tests [MAX_TESTS][9];
  int      num_tests = 0;
  sample_t exp_mem [`BUF_CHANNELS][TOTAL];
  int      exp_cnt [`BUF_CHANNELS];
  sample_t exp_stream [$];
  int      active;
  int      errors = 0;
  int      checks = 0;
  int      cycle_count = 0;
  int      cycle_limit = 0;
  logic [15:0] lfsr = 16'd19;

  sample_buffer UUT (
    .ps_clk,
    .ps_reset,
    .arm_i               (arm),
    .sw_start_i          (sw_start),
    .sw_stop_i           (sw_stop),
    .hw_start_i          (hw_start),
    .hw_stop_i           (hw_stop),
    .capture_reset_i     (capture_reset),
    .readout_start_i     (readout_start),
    .readout_reset_i     (readout_reset),
    .banking_mode_i      (banking_mode),
    .sample_data_i       (sample_data),
    .sample_valid_i      (sample_valid),
    .capture_full_o      (capture_full),
    .write_depth_o       (write_depth),
    .write_depth_valid_o (depth_valid),
    .write_depth_ready_i (depth_ready),
    .readout_data_o      (readout_data),
    .readout_valid_o     (readout_valid),
    .readout_ready_i     (readout_ready),
    .readout_last_o      (readout_last)
  );

  bind sample_buffer sample_buffer_chk u_chk (
    .ps_clk              (ps_clk),
    .ps_reset            (ps_reset),
    .capture_reset_i     (capture_reset_i),
    .readout_reset_i     (readout_reset_i),
    .capture_full_i      (capture_full_o),
    .write_depth_i       (write_depth_o),
    .write_depth_valid_i (write_depth_valid_o),
    .write_depth_ready_i (write_depth_ready_i),
    .readout_data_i      (readout_data_o),
    .readout_valid_i     (readout_valid_o),
    .readout_ready_i     (readout_ready_i),
    .readout_last_i      (readout_last_o)
  );

  initial begin
    ps_clk = 1'b0;
    forever #50 ps_clk = ~ps_clk;
  end

  always @(posedge ps_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Error: run did not end within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  // taps 16, 14, 13, 11
  function automatic logic next_random_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic sample_t random_sample();
    sample_t s;
    s = '0;
    for (int i = 0; i < $bits(sample_t); i++) begin
      s = {s[$bits(sample_t)-2:0], next_random_bit()};
    end
    return s;
  endfunction

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Error: %s", what);
  endtask

  task automatic clear_strobes();
    arm           = 1'b0;
    sw_start      = 1'b0;
    sw_stop       = 1'b0;
    hw_start      = 1'b0;
    hw_stop       = 1'b0;
    capture_reset = 1'b0;
    readout_start = 1'b0;
    readout_reset = 1'b0;
    depth_ready   = 1'b0;
  endtask

  // on the falling edge clear strobes and present fresh samples
  // samples that capture should keep are recorded
  task automatic capture_cycle(input bit store);
    @(negedge ps_clk);
    clear_strobes();
    for (int c = 0; c < `BUF_CHANNELS; c++) begin
      sample_data[c] = random_sample();
      if (store && c < active) begin
        sample_valid[c] = 1'b1;
        exp_mem[c][exp_cnt[c]] = sample_data[c];
        exp_cnt[c]++;
      end else begin
        sample_valid[c] = next_random_bit();
      end
    end
  endtask

  // accept words under random ready
  // a transfer lands on the next rising edge
  task automatic read_stream(input int words);
    int idx;
    int waited;
    idx    = 0;
    waited = 0;
    while (idx < words && waited < 40 + 4 * words) begin
      capture_cycle(0);
      readout_ready = next_random_bit();
      waited++;
      if (readout_valid && readout_ready) begin
        compare("readout_data_o", readout_data, exp_stream[idx]);
        compare("readout_last_o", readout_last, idx == exp_stream.size() - 1);
        idx++;
      end
    end
    if (idx < words) begin
      report_failure("readout stalled before all words arrived");
    end
  endtask

  task automatic run_test(input int t);
    int          errors_before;
    int          waited;
    int          seen;
    bit          expect_word;
    depth_word_t file_word;
    depth_word_t own_word;
    errors_before = errors;
    banking_mode  = banking_mode_t'(tests[t][0]);
    active        = 1 << tests[t][0];
    // every test begins from idle with empty counts
    capture_cycle(0);
    capture_reset = 1'b1;
    exp_cnt       = '{default: 0};
    if (tests[t][1] == 1) begin
      capture_cycle(0);
      arm = 1'b1;
    end
    capture_cycle(0);
    if (tests[t][1] == 0) begin
      sw_start = 1'b1;
    end else begin
      hw_start = 1'b1;
    end
    for (int i = 0; i < tests[t][3]; i++) begin
      capture_cycle(tests[t][1] != 2);
    end
    capture_cycle(0);
    case (tests[t][2])
      0: sw_stop = 1'b1;
      1: hw_stop = 1'b1;
      3: begin
        capture_reset = 1'b1;
        exp_cnt       = '{default: 0};
      end
      default: ;
    endcase

    expect_word = (tests[t][1] != 2) && (tests[t][2] != 3);
    for (int c = 0; c < `BUF_CHANNELS; c++) begin
      file_word[c] = depth_t'(tests[t][4 + c]);
      own_word[c]  = depth_t'(exp_cnt[c]);
    end
    waited = 0;
    while (!depth_valid && waited < 8) begin
      capture_cycle(0);
      waited++;
    end
    if (!expect_word) begin
      compare("write_depth_valid_o", depth_valid, 1'b0);
    end else if (!depth_valid) begin
      report_failure("write depth word never appeared");
    end else begin
      compare("write_depth_o", write_depth, file_word);
      compare("write_depth_o", write_depth, own_word);
      compare("capture_full_o", capture_full, tests[t][2] == 2);
      capture_cycle(0);
      depth_ready = 1'b1;
      // the word is offered only once
      repeat (4) begin
        capture_cycle(0);
        compare("write_depth_valid_o", depth_valid, 1'b0);
      end
    end

    exp_stream.delete();
    for (int c = 0; c < `BUF_CHANNELS; c++) begin
      for (int i = 0; i < exp_cnt[c]; i++) begin
        exp_stream.push_back(exp_mem[c][i]);
      end
    end
    capture_cycle(0);
    readout_start = 1'b1;
    readout_ready = 1'b0;
    if (exp_stream.size() == 0) begin
      seen = 0;
      repeat (10) begin
        capture_cycle(0);
        readout_ready = next_random_bit();
        if (readout_valid) begin
          seen++;
        end
      end
      compare("readout_valid_o", seen != 0, 1'b0);
    end else begin
      if (tests[t][8] != 0) begin
        read_stream(exp_stream.size() / 2);
        capture_cycle(0);
        readout_reset = 1'b1;
        readout_ready = 1'b0;
        capture_cycle(0);
        compare("readout_valid_o", readout_valid, 1'b0);
        readout_start = 1'b1;
      end
      read_stream(exp_stream.size());
      repeat (4) begin
        capture_cycle(0);
        readout_ready = 1'b1;
        compare("readout_valid_o", readout_valid, 1'b0);
      end
    end
    $display("test %0d mode %0d trigger %0d stop %0d: %0d errors", t, tests[t][0],
             tests[t][1], tests[t][2], errors - errors_before);
  endtask

  initial begin
    int    fd;
    int    fields;
    int    run_sum;
    string line;
    ps_reset      = 1'b1;
    banking_mode  = '0;
    sample_data   = '0;
    sample_valid  = '0;
    readout_ready = 1'b0;
    clear_strobes();
    run_sum = 0;
    fd = $fopen("verif/sample_buffer_testdata.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open verif/sample_buffer_testdata.txt");
    end else begin
      while (!$feof(fd) && num_tests < MAX_TESTS) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          fields = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                           tests[num_tests][0], tests[num_tests][1], tests[num_tests][2],
                           tests[num_tests][3], tests[num_tests][4], tests[num_tests][5],
                           tests[num_tests][6], tests[num_tests][7], tests[num_tests][8]);
          if (fields == 9) begin
            run_sum += tests[num_tests][3];
            num_tests++;
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = run_sum + 200 * num_tests;

    repeat (3) @(negedge ps_clk);
    ps_reset = 1'b0;
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end

    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             num_tests, checks, errors, UUT.u_chk.failures);
    if (errors == 0 && UUT.u_chk.failures == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: verif/sample_buffer_testdata.txt
# mode trigger(0 sw, 1 hw after arm, 2 hw unarmed) stop(0 sw, 1 hw, 2 full, 3 capture reset)
# cycles depth0 depth1 depth2 depth3 readout_reset
0 0 0 12 12 0 0 0 0
1 0 1 9 9 9 0 0 0
2 0 0 7 7 7 7 7 0
1 1 0 10 10 10 0 0 1
2 2 0 8 0 0 0 0 0
2 1 2 16 16 16 16 16 0
1 0 2 32 32 32 0 0 0
0 1 2 64 64 0 0 0 0
2 0 3 5 0 0 0 0 0
2 1 1 6 6 6 6 6 1
0 0 1 20 20 0 0 0 1
